// ==== testbench/board_stim.txt ====
# op      arg0      arg1  arg2    all values hex
# reset hold game | dload len game | status word dip | joy joys btns out | pause dl pair
reset     10        8     0
dload     5         8     0
status    00000000  060   0
status    00000004  260   0
status    00000018  1e0   0
status    00000060  000   0
status    00000080  070   0
status    00000100  068   0
status    00000c00  063   0
status    00000a5c  3c6   0
status    00000000  060   0
joy       00000000  0     ffffff
joy       00010002  5     ffbfda
joy       fc0003ff  c     ffc003
joy       00100000  0     fbffff
status    00000200  064   0
joy       00010002  5     ff7fea
status    00000000  060   0
pause     0         3     0
pause     1         3     0
pause     0         0     0
status    00040000  060   0
joy       00100000  0     fbffff
fire      6         0     0
joy       00000000  0     ffffff
status    00000000  060   0
led       1         0     1
led       0         1     1
led       0         2     0
led       1         2     1
blink     c         4     0
video     20        0     0

// ==== project.f ====
source/board_cfg_pkg.sv
source/board_types_pkg.sv
source/board_reset.sv
source/board_dip.sv
source/board_inputs.sv
source/board_led.sv
source/board_video.sv
source/board_top.sv
testbench/board_checker.sv
testbench/tb_board.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_board -f project.f -o tb_board
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/tb_board)
sim_status=$?
printf '%s\n' "$output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// ==== testbench/tb_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board;

    localparam string STIM_FILE = "testbench/board_stim.txt";

    logic                                 clk_sys;
    logic                                 rst_n;
    logic                                 rst_req;
    logic                                 pll_locked;
    logic                                 downloading;
    logic [board_cfg_pkg::STATUSW-1:0]    status;
    logic                                 osd_shown;
    logic [1:0]                           game_led;
    logic [board_cfg_pkg::BOARD_JOYW-1:0] board_joy1;
    logic [board_cfg_pkg::BOARD_JOYW-1:0] board_joy2;
    logic [board_cfg_pkg::PLAYERS-1:0]    board_start;
    logic [board_cfg_pkg::PLAYERS-1:0]    board_coin;
    logic                                 pause_key;
    logic [board_cfg_pkg::COLORW-1:0]     game_r;
    logic [board_cfg_pkg::COLORW-1:0]     game_g;
    logic [board_cfg_pkg::COLORW-1:0]     game_b;
    logic                                 lhbl;
    logic                                 lvbl;
    logic                                 hs;
    logic                                 vs;
    logic                                 pxl_cen;

    logic                                 board_rst_n;
    logic                                 game_rst_n;
    logic                                 rotate;
    logic [1:0]                           scanlines;
    logic                                 enable_fm;
    logic                                 enable_psg;
    logic                                 dip_test;
    logic                                 dip_pause;
    logic                                 dip_flip;
    logic [1:0]                           dip_fxlevel;
    logic [board_cfg_pkg::JOYW-1:0]       game_joy1;
    logic [board_cfg_pkg::JOYW-1:0]       game_joy2;
    logic [board_cfg_pkg::PLAYERS-1:0]    game_start;
    logic [board_cfg_pkg::PLAYERS-1:0]    game_coin;
    logic                                 game_pause;
    logic                                 led;
    logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_r;
    logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_g;
    logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_b;
    logic                                 vid_hs;
    logic                                 vid_vs;
    logic                                 vid_de;

    int              mismatch_count;
    int              failure_count;
    logic [31:0]     seed;
    logic [8*160-1:0] line;
    string           op;
    string           name;
    logic [31:0]     arg0;
    logic [31:0]     arg1;
    logic [31:0]     arg2;
    int              fd;
    int              fields;
    int              step_no;

    board_top DUT (.*);

    board_checker u_checker (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic advance(input int cycles);
        repeat (cycles) @(negedge clk_sys);
    endtask

    task automatic sequence_reset();
        pll_locked = 1'b0;
        advance(2);
        pll_locked = 1'b1;
        u_checker.reset_check(name, arg0, arg1);
    endtask

    task automatic pulse_download();
        downloading = 1'b1;
        advance(1);
        // Board stays up, game drops
        u_checker.level_check(name, 32'b10);
        advance(arg0 - 1);
        downloading = 1'b0;
        u_checker.release_check(name, arg1);
    endtask

    task automatic pulse_pause();
        pause_key   = 1'b1;
        downloading = arg0[0];
        advance(1);
        pause_key   = 1'b0;
        downloading = 1'b0;
        advance(1);
        u_checker.pause_check(name, arg1);
    endtask

    task automatic run_autofire();
        logic expected;
        int   edge_no;
        expected = arg1[0];
        u_checker.fire_check(name, 32'(expected));
        for (edge_no = 0; edge_no < arg0; edge_no++) begin
            vs       = 1'b1;
            expected = ~expected;
            advance(1);
            u_checker.fire_check(name, 32'(expected));
            advance(1);
            u_checker.fire_check(name, 32'(expected));
            // Falling vs must leave the button alone
            vs = 1'b0;
            advance(2);
            u_checker.fire_check(name, 32'(expected));
        end
    endtask

    task automatic show_frames();
        int frame;
        downloading = 1'b1;
        osd_shown   = 1'b0;
        lvbl        = 1'b1;
        advance(2);
        u_checker.led_check(name, 32'd0);
        for (frame = 1; frame <= arg0; frame++) begin
            lvbl = 1'b0;
            advance(3);
            u_checker.led_check(name, (frame / arg1) % 2);
            lvbl = 1'b1;
            advance(2);
        end
        downloading = 1'b0;
        advance(1);
    endtask

    task automatic drive_pixels();
        int          pixel;
        logic [26:0] expected;
        for (pixel = 0; pixel < arg0; pixel++) begin
            seed   = lcg_next(seed);
            game_r = seed[11:8];
            game_g = seed[15:12];
            game_b = seed[19:16];
            lhbl   = seed[20] | seed[21];
            lvbl   = seed[22] | seed[23];
            hs     = seed[24];
            vs     = seed[25];
            // Active area shows each nibble twice, blanking shows black
            if (lhbl && lvbl) begin
                expected = {game_r, game_r, game_g, game_g, game_b, game_b, hs, vs, 1'b1};
            end else begin
                expected = {24'd0, hs, vs, 1'b0};
            end
            pxl_cen = 1'b1;
            advance(1);
            u_checker.video_check(name, 32'(expected));
            pxl_cen = 1'b0;
            seed    = lcg_next(seed);
            {game_r, game_g, game_b} = seed[27:16];
            advance(1);
            u_checker.video_check(name, 32'(expected));
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        rst_req     = 1'b0;
        pll_locked  = 1'b0;
        downloading = 1'b0;
        status      = '0;
        osd_shown   = 1'b0;
        game_led    = 2'b00;
        board_joy1  = '0;
        board_joy2  = '0;
        board_start = '0;
        board_coin  = '0;
        pause_key   = 1'b0;
        game_r      = '0;
        game_g      = '0;
        game_b      = '0;
        lhbl        = 1'b0;
        lvbl        = 1'b0;
        hs          = 1'b0;
        vs          = 1'b0;
        pxl_cen     = 1'b0;
        seed        = 32'hc57d4e8b;
        step_no     = 0;
        advance(3);
        rst_n = 1'b1;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            u_checker.note_failure("could not open the stim file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %h %h %h", op, arg0, arg1, arg2);
                if (fields >= 1 && op != "#") begin
                    step_no++;
                    name = $sformatf("step %0d %s", step_no, op);
                    if (fields != 4) begin
                        u_checker.note_failure({name, ": stim line has missing fields"});
                    end else begin
                        case (op)
                            "reset": sequence_reset();
                            "dload": pulse_download();
                            "status": begin
                                status = arg0;
                                advance(1);
                                u_checker.dip_check(name, arg1);
                            end
                            "joy": begin
                                {board_joy1, board_joy2}  = arg0;
                                {board_start, board_coin} = arg1[3:0];
                                advance(1);
                                u_checker.joy_check(name, arg2);
                            end
                            "pause": pulse_pause();
                            "fire":  run_autofire();
                            "led": begin
                                osd_shown = arg0[0];
                                game_led  = arg1[1:0];
                                advance(1);
                                u_checker.led_check(name, arg2);
                            end
                            "blink": show_frames();
                            "video": drive_pixels();
                            default: begin
                                u_checker.note_failure({name, ": unknown stim operation"});
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/board_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_checker (
    input  logic                                 clk_sys,
    input  logic                                 board_rst_n,
    input  logic                                 game_rst_n,
    input  logic                                 rotate,
    input  logic [1:0]                           scanlines,
    input  logic                                 enable_fm,
    input  logic                                 enable_psg,
    input  logic                                 dip_test,
    input  logic                                 dip_pause,
    input  logic                                 dip_flip,
    input  logic [1:0]                           dip_fxlevel,
    input  logic [board_cfg_pkg::JOYW-1:0]       game_joy1,
    input  logic [board_cfg_pkg::JOYW-1:0]       game_joy2,
    input  logic [board_cfg_pkg::PLAYERS-1:0]    game_start,
    input  logic [board_cfg_pkg::PLAYERS-1:0]    game_coin,
    input  logic                                 game_pause,
    input  logic                                 led,
    input  logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_r,
    input  logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_g,
    input  logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_b,
    input  logic                                 vid_hs,
    input  logic                                 vid_vs,
    input  logic                                 vid_de,
    output int                                   mismatch_count,
    output int                                   failure_count
);

    // Longest wait for a reset to release
    localparam int RISE_LIMIT = 64;

    initial begin
        mismatch_count = 0;
        failure_count  = 0;
    end

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic note_failure(input string what);
        failure_count++;
        $display("%s", what);
    endtask

    // Cycles from now until the chosen reset output is seen high
    task automatic count_to_rise(input string name, input bit game, output int cycles);
        int waited;
        cycles = -1;
        for (waited = 1; waited <= RISE_LIMIT; waited++) begin
            @(negedge clk_sys);
            if ((game ? game_rst_n : board_rst_n) === 1'b1) begin
                cycles = waited;
                break;
            end
        end
        if (cycles < 0) begin
            note_failure($sformatf("%s: reset still low after %0d cycles", name, RISE_LIMIT));
        end
    endtask

    task automatic reset_check(input string name, input int board_exp, input int game_exp);
        int cycles;
        count_to_rise(name, 1'b0, cycles);
        if (cycles > 0) begin
            report({name, " board release"}, board_exp, cycles);
        end
        count_to_rise(name, 1'b1, cycles);
        if (cycles > 0) begin
            report({name, " game release"}, game_exp, cycles);
        end
    endtask

    task automatic release_check(input string name, input int game_exp);
        int cycles;
        count_to_rise(name, 1'b1, cycles);
        if (cycles > 0) begin
            report({name, " game release"}, game_exp, cycles);
        end
    endtask

    task automatic level_check(input string name, input logic [31:0] exp);
        report(name, exp, 32'({board_rst_n, game_rst_n}));
    endtask

    task automatic dip_check(input string name, input logic [31:0] exp);
        report(name, exp, 32'({rotate, scanlines, enable_fm, enable_psg, dip_test,
                              dip_pause, dip_flip, dip_fxlevel}));
    endtask

    task automatic joy_check(input string name, input logic [31:0] exp);
        report(name, exp, 32'({game_joy1, game_joy2, game_start, game_coin}));
    endtask

    task automatic pause_check(input string name, input logic [31:0] exp);
        report(name, exp, 32'({game_pause, dip_pause}));
    endtask

    task automatic fire_check(input string name, input logic [31:0] exp);
        report(name, exp, 32'(game_joy1[board_cfg_pkg::JOY_BTN0]));
    endtask

    task automatic led_check(input string name, input logic [31:0] exp);
        report(name, exp, 32'(led));
    endtask

    task automatic video_check(input string name, input logic [31:0] exp);
        report(name, exp, 32'({vid_r, vid_g, vid_b, vid_hs, vid_vs, vid_de}));
    endtask

endmodule

`default_nettype wire

// ==== source/board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  logic                                 rst_req,
    input  logic                                 pll_locked,
    input  logic                                 downloading,
    input  logic [board_cfg_pkg::STATUSW-1:0]    status,
    input  logic                                 osd_shown,
    input  logic [1:0]                           game_led,
    input  logic [board_cfg_pkg::BOARD_JOYW-1:0] board_joy1,
    input  logic [board_cfg_pkg::BOARD_JOYW-1:0] board_joy2,
    input  logic [board_cfg_pkg::PLAYERS-1:0]    board_start,
    input  logic [board_cfg_pkg::PLAYERS-1:0]    board_coin,
    input  logic                                 pause_key,
    input  logic [board_cfg_pkg::COLORW-1:0]     game_r,
    input  logic [board_cfg_pkg::COLORW-1:0]     game_g,
    input  logic [board_cfg_pkg::COLORW-1:0]     game_b,
    input  logic                                 lhbl,
    input  logic                                 lvbl,
    input  logic                                 hs,
    input  logic                                 vs,
    input  logic                                 pxl_cen,
    output logic                                 board_rst_n,
    output logic                                 game_rst_n,
    output logic                                 rotate,
    output logic [1:0]                           scanlines,
    output logic                                 enable_fm,
    output logic                                 enable_psg,
    output logic                                 dip_test,
    output logic                                 dip_pause,
    output logic                                 dip_flip,
    output logic [1:0]                           dip_fxlevel,
    output logic [board_cfg_pkg::JOYW-1:0]       game_joy1,
    output logic [board_cfg_pkg::JOYW-1:0]       game_joy2,
    output logic [board_cfg_pkg::PLAYERS-1:0]    game_start,
    output logic [board_cfg_pkg::PLAYERS-1:0]    game_coin,
    output logic                                 game_pause,
    output logic                                 led,
    output logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_r,
    output logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_g,
    output logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_b,
    output logic                                 vid_hs,
    output logic                                 vid_vs,
    output logic                                 vid_de
);

    logic autofire_en;

    board_reset u_reset (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .pll_locked  (pll_locked),
        .rst_req     (rst_req),
        .downloading (downloading),
        .dip_flip    (dip_flip),
        .board_rst_n (board_rst_n),
        .game_rst_n  (game_rst_n)
    );

    board_dip u_dip (
        .clk_sys     (clk_sys),
        .board_rst_n (board_rst_n),
        .status      (status),
        .game_pause  (game_pause),
        .rotate      (rotate),
        .scanlines   (scanlines),
        .enable_fm   (enable_fm),
        .enable_psg  (enable_psg),
        .dip_test    (dip_test),
        .dip_pause   (dip_pause),
        .dip_flip    (dip_flip),
        .dip_fxlevel (dip_fxlevel),
        .autofire_en (autofire_en)
    );

    board_inputs u_inputs (
        .clk_sys     (clk_sys),
        .board_rst_n (board_rst_n),
        .downloading (downloading),
        .vs          (vs),
        .autofire_en (autofire_en),
        .dip_flip    (dip_flip),
        .pause_key   (pause_key),
        .board_joy1  (board_joy1),
        .board_joy2  (board_joy2),
        .board_start (board_start),
        .board_coin  (board_coin),
        .game_joy1   (game_joy1),
        .game_joy2   (game_joy2),
        .game_start  (game_start),
        .game_coin   (game_coin),
        .game_pause  (game_pause)
    );

    board_led u_led (
        .clk_sys     (clk_sys),
        .board_rst_n (board_rst_n),
        .downloading (downloading),
        .osd_shown   (osd_shown),
        .lvbl        (lvbl),
        .game_led    (game_led),
        .led         (led)
    );

    board_video u_video (
        .clk_sys     (clk_sys),
        .board_rst_n (board_rst_n),
        .pxl_cen     (pxl_cen),
        .lhbl        (lhbl),
        .lvbl        (lvbl),
        .hs          (hs),
        .vs          (vs),
        .game_r      (game_r),
        .game_g      (game_g),
        .game_b      (game_b),
        .vid_r       (vid_r),
        .vid_g       (vid_g),
        .vid_b       (vid_b),
        .vid_hs      (vid_hs),
        .vid_vs      (vid_vs),
        .vid_de      (vid_de)
    );

endmodule

`default_nettype wire

// ==== source/board_video.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_video (
    input  logic                                 clk_sys,
    input  logic                                 board_rst_n,
    input  logic                                 pxl_cen,
    input  logic                                 lhbl,
    input  logic                                 lvbl,
    input  logic                                 hs,
    input  logic                                 vs,
    input  logic [board_cfg_pkg::COLORW-1:0]     game_r,
    input  logic [board_cfg_pkg::COLORW-1:0]     game_g,
    input  logic [board_cfg_pkg::COLORW-1:0]     game_b,
    output logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_r,
    output logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_g,
    output logic [board_cfg_pkg::VIDEO_OUTW-1:0] vid_b,
    output logic                                 vid_hs,
    output logic                                 vid_vs,
    output logic                                 vid_de
);

    logic de_in;

    assign de_in = lhbl & lvbl;

    always_ff @(posedge clk_sys) begin
        if (!board_rst_n) begin
            vid_r  <= '0;
            vid_g  <= '0;
            vid_b  <= '0;
            vid_hs <= 1'b0;
            vid_vs <= 1'b0;
            vid_de <= 1'b0;
        end else if (pxl_cen) begin
            vid_hs <= hs;
            vid_vs <= vs;
            vid_de <= de_in;
            // Nibble repeated so full scale stays full scale
            vid_r  <= de_in ? {game_r, game_r} : '0;
            vid_g  <= de_in ? {game_g, game_g} : '0;
            vid_b  <= de_in ? {game_b, game_b} : '0;
        end
    end

    assert property (@(posedge clk_sys) !vid_de |-> ((vid_r | vid_g | vid_b) == '0));

endmodule

`default_nettype wire

// ==== source/board_led.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_led (
    input  logic       clk_sys,
    input  logic       board_rst_n,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic       lvbl,
    input  logic [1:0] game_led,
    output logic       led
);

    board_types_pkg::led_mode_e         mode;
    logic [board_cfg_pkg::LED_CNTW-1:0] frame_cnt;
    logic                               lvbl_l;
    logic                               lvbl_fall;
    logic                               blink;

    assign lvbl_fall = lvbl_l & ~lvbl;

    // Download has priority, then the OSD
    always_comb begin
        if (downloading) begin
            mode = board_types_pkg::LED_BLINK;
        end else if (osd_shown) begin
            mode = board_types_pkg::LED_OSD;
        end else begin
            mode = board_types_pkg::LED_GAME;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!board_rst_n) begin
            lvbl_l    <= 1'b0;
            frame_cnt <= '0;
            blink     <= 1'b0;
            led       <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (mode != board_types_pkg::LED_BLINK) begin
                frame_cnt <= '0;
                blink     <= 1'b0;
            end else if (lvbl_fall) begin
                if (frame_cnt == board_cfg_pkg::LED_BLINK_LAST) begin
                    frame_cnt <= '0;
                    blink     <= ~blink;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            case (mode)
                board_types_pkg::LED_BLINK: led <= blink;
                board_types_pkg::LED_OSD:   led <= 1'b1;
                default:                    led <= game_led[0];
            endcase
        end
    end

    assert property (@(posedge clk_sys) $rose(board_rst_n) |-> !led);

endmodule

`default_nettype wire

// ==== source/board_inputs.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_inputs (
    input  logic                                 clk_sys,
    input  logic                                 board_rst_n,
    input  logic                                 downloading,
    input  logic                                 vs,
    input  logic                                 autofire_en,
    input  logic                                 dip_flip,
    input  logic                                 pause_key,
    input  logic [board_cfg_pkg::BOARD_JOYW-1:0] board_joy1,
    input  logic [board_cfg_pkg::BOARD_JOYW-1:0] board_joy2,
    input  logic [board_cfg_pkg::PLAYERS-1:0]    board_start,
    input  logic [board_cfg_pkg::PLAYERS-1:0]    board_coin,
    output logic [board_cfg_pkg::JOYW-1:0]       game_joy1,
    output logic [board_cfg_pkg::JOYW-1:0]       game_joy2,
    output logic [board_cfg_pkg::PLAYERS-1:0]    game_start,
    output logic [board_cfg_pkg::PLAYERS-1:0]    game_coin,
    output logic                                 game_pause
);

    logic [board_cfg_pkg::JOYW-1:0]    joy_raw  [board_cfg_pkg::PLAYERS];
    logic [board_cfg_pkg::JOYW-1:0]    joy_fire [board_cfg_pkg::PLAYERS];
    logic [board_cfg_pkg::PLAYERS-1:0] fire_phase;
    logic [board_cfg_pkg::PLAYERS-1:0] phase_nxt;
    logic [board_cfg_pkg::JOYW-1:0]    joy_pol;
    logic [board_cfg_pkg::PLAYERS-1:0] btn_pol;
    logic                              vs_l;
    logic                              pause_l;
    logic                              vs_rise;

    // XOR masks, also the idle level out of reset
    assign joy_pol = {board_cfg_pkg::JOYW{board_cfg_pkg::GAME_INPUTS_ACTIVE_LOW}};
    assign btn_pol = {board_cfg_pkg::PLAYERS{board_cfg_pkg::GAME_INPUTS_ACTIVE_LOW}};

    assign joy_raw[0] = board_joy1[board_cfg_pkg::JOYW-1:0];
    assign joy_raw[1] = board_joy2[board_cfg_pkg::JOYW-1:0];
    assign vs_rise    = vs & ~vs_l;

    // Autofire pulses button 0 once per frame
    always_comb begin
        for (int p = 0; p < board_cfg_pkg::PLAYERS; p++) begin
            if (!autofire_en || !joy_raw[p][board_cfg_pkg::JOY_BTN0]) begin
                phase_nxt[p] = 1'b1;
            end else if (vs_rise) begin
                phase_nxt[p] = ~fire_phase[p];
            end else begin
                phase_nxt[p] = fire_phase[p];
            end
            joy_fire[p] = joy_raw[p];
            joy_fire[p][board_cfg_pkg::JOY_BTN0] =
                joy_raw[p][board_cfg_pkg::JOY_BTN0] & phase_nxt[p];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!board_rst_n) begin
            vs_l       <= 1'b0;
            pause_l    <= 1'b0;
            fire_phase <= '1;
            game_pause <= 1'b0;
            game_joy1  <= joy_pol;
            game_joy2  <= joy_pol;
            game_start <= btn_pol;
            game_coin  <= btn_pol;
        end else begin
            vs_l       <= vs;
            pause_l    <= pause_key;
            fire_phase <= phase_nxt;
            if (pause_key && !pause_l && !downloading) begin
                game_pause <= ~game_pause;
            end
            // Cocktail cabinet swaps the players when flipped
            game_joy1  <= (dip_flip ? joy_fire[1] : joy_fire[0]) ^ joy_pol;
            game_joy2  <= (dip_flip ? joy_fire[0] : joy_fire[1]) ^ joy_pol;
            game_start <= board_start ^ btn_pol;
            game_coin  <= board_coin ^ btn_pol;
        end
    end

endmodule

`default_nettype wire

// ==== source/board_dip.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_dip (
    input  logic                              clk_sys,
    input  logic                              board_rst_n,
    input  logic [board_cfg_pkg::STATUSW-1:0] status,
    input  logic                              game_pause,
    output logic                              rotate,
    output logic [1:0]                        scanlines,
    output logic                              enable_fm,
    output logic                              enable_psg,
    output logic                              dip_test,
    output logic                              dip_pause,
    output logic                              dip_flip,
    output logic [1:0]                        dip_fxlevel,
    output logic                              autofire_en
);

    always_ff @(posedge clk_sys) begin
        if (!board_rst_n) begin
            rotate      <= 1'b0;
            scanlines   <= 2'd0;
            enable_fm   <= 1'b0;
            enable_psg  <= 1'b0;
            dip_test    <= 1'b0;
            dip_pause   <= 1'b0;
            dip_flip    <= 1'b0;
            dip_fxlevel <= 2'd0;
            autofire_en <= 1'b0;
        end else begin
            rotate      <= status[board_cfg_pkg::ST_ROTATE];
            scanlines   <= status[board_cfg_pkg::ST_SCANLINES +: 2];
            // OSD stores these as off switches
            enable_fm   <= ~status[board_cfg_pkg::ST_FM_OFF];
            enable_psg  <= ~status[board_cfg_pkg::ST_PSG_OFF];
            dip_test    <= status[board_cfg_pkg::ST_TEST];
            // Either the OSD or the pause key can stop the game
            dip_pause   <= status[board_cfg_pkg::ST_PAUSE] | game_pause;
            dip_flip    <= status[board_cfg_pkg::ST_FLIP];
            dip_fxlevel <= status[board_cfg_pkg::ST_FX +: 2];
            autofire_en <= status[board_cfg_pkg::ST_AUTOFIRE];
        end
    end

endmodule

`default_nettype wire

// ==== source/board_reset.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_reset (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    input  logic dip_flip,
    output logic board_rst_n,
    output logic game_rst_n
);

    board_types_pkg::rst_state_e        state;
    logic [board_cfg_pkg::RST_CNTW-1:0] cnt;
    logic                               flip_l;
    logic                               hold_cause;
    logic                               game_restart;

    // Any of these holds the whole board
    assign hold_cause   = ~rst_n | ~pll_locked | rst_req;
    // Flipping the screen needs a fresh game start
    assign game_restart = downloading | (dip_flip ^ flip_l);

    always_ff @(posedge clk_sys) begin
        if (hold_cause) begin
            state       <= board_types_pkg::RST_BOARD;
            cnt         <= '0;
            flip_l      <= 1'b0;
            board_rst_n <= 1'b0;
            game_rst_n  <= 1'b0;
        end else begin
            flip_l <= dip_flip;
            case (state)
                board_types_pkg::RST_BOARD: begin
                    if (cnt == board_cfg_pkg::RST_HOLD_LAST) begin
                        board_rst_n <= 1'b1;
                        cnt         <= '0;
                        state       <= board_types_pkg::RST_GAME;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                board_types_pkg::RST_GAME: begin
                    // Delay restarts while a download or flip change is seen
                    if (game_restart) begin
                        cnt <= '0;
                    end else if (cnt == board_cfg_pkg::GAME_RST_LAST) begin
                        game_rst_n <= 1'b1;
                        state      <= board_types_pkg::RST_RUN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                board_types_pkg::RST_RUN: begin
                    if (game_restart) begin
                        game_rst_n <= 1'b0;
                        cnt        <= '0;
                        state      <= board_types_pkg::RST_GAME;
                    end
                end
                default: begin
                    state <= board_types_pkg::RST_BOARD;
                end
            endcase
        end
    end

    // Game never runs ahead of the board
    assert property (@(posedge clk_sys) !board_rst_n |-> !game_rst_n);

endmodule

`default_nettype wire

// ==== source/board_types_pkg.sv ====
`default_nettype none

package board_types_pkg;

    // Reset sequencer phases
    typedef enum logic [1:0] {
        RST_BOARD,
        RST_GAME,
        RST_RUN
    } rst_state_e;

    // Where the LED level comes from
    typedef enum logic [1:0] {
        LED_GAME,
        LED_OSD,
        LED_BLINK
    } led_mode_e;

endpackage

`default_nettype wire

// ==== source/board_cfg_pkg.sv ====
`default_nettype none

package board_cfg_pkg;

    // Video widths
    localparam int COLORW     = 4;
    localparam int VIDEO_OUTW = 8;

    // Player inputs
    localparam int JOYW       = 10;
    localparam int BOARD_JOYW = 16;
    localparam int PLAYERS    = 2;
    localparam int JOY_BTN0   = 4;
    localparam bit GAME_INPUTS_ACTIVE_LOW = 1'b1;

    // OSD status word layout
    localparam int STATUSW      = 32;
    localparam int ST_ROTATE    = 2;
    localparam int ST_SCANLINES = 3;
    localparam int ST_FM_OFF    = 5;
    localparam int ST_PSG_OFF   = 6;
    localparam int ST_TEST      = 7;
    localparam int ST_PAUSE     = 8;
    localparam int ST_FLIP      = 9;
    localparam int ST_FX        = 10;
    localparam int ST_AUTOFIRE  = 18;

    // Reset sequencing, one counter shared by both phases
    localparam int RST_HOLD_CYCLES = 16;
    localparam int GAME_RST_DELAY  = 8;
    localparam int RST_CNTW        = 5;
    localparam logic [RST_CNTW-1:0] RST_HOLD_LAST = RST_CNTW'(RST_HOLD_CYCLES - 1);
    localparam logic [RST_CNTW-1:0] GAME_RST_LAST = RST_CNTW'(GAME_RST_DELAY - 1);

    // LED blink, frames per half period
    localparam int LED_BLINK_FRAMES = 4;
    localparam int LED_CNTW         = 2;
    localparam logic [LED_CNTW-1:0] LED_BLINK_LAST = LED_CNTW'(LED_BLINK_FRAMES - 1);

endpackage

`default_nettype wire
